// File: hdl/spi_reg_pkg.sv
package spi_reg_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame geometry
    //////////////////////////////////////////////////////////////////////

    // register address, msb first after the r/w flag
    localparam int ADDR_W     = 7;
    // data byte, last field of the frame
    localparam int DATA_W     = 8;
    // flag + address + data
    localparam int FRAME_BITS = 1 + ADDR_W + DATA_W;

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // read-only status byte, top of the address map
    localparam reg_addr_t STATUS_ADDR = 7'h7F;

    //////////////////////////////////////////////////////////////////////
    // block to block bundles
    //////////////////////////////////////////////////////////////////////

    // host pins after the synchronizer
    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_pins_t;

    // single-cycle enables in clk
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        logic cs_end;
    } spi_edges_t;

    // one register access, strobes are single pulses
    typedef struct packed {
        logic      rd_stb;
        logic      wr_stb;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

endpackage

// File: hdl/spi_pin_sync.sv
`timescale 1ns/100ps

module spi_pin_sync (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    spi_cs0,
    input  logic                    spi_clk,
    input  logic                    spi_mosi,
    output spi_reg_pkg::spi_pins_t  pins,
    output spi_reg_pkg::spi_edges_t edges
);
    import spi_reg_pkg::*;

    // raw host pins bundled for the sampling chain
    spi_pins_t pin_raw;
    // two-flop synchronizer stages
    spi_pins_t sync1;
    spi_pins_t sync2;
    // previous value, compared against sync2
    spi_pins_t sync3;

    assign pin_raw.cs   = spi_cs0;
    assign pin_raw.sclk = spi_clk;
    assign pin_raw.mosi = spi_mosi;

    //////////////////////////////////////////////////////////////////////
    // three-stage sampling of all host pins
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sync1 <= '0;
            sync2 <= '0;
            sync3 <= '0;
        end else begin
            sync1 <= pin_raw;
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    // third stage lines up with the registered enables
    assign pins = sync3;

    //////////////////////////////////////////////////////////////////////
    // edge enables
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            edges <= '0;
        end else begin
            // spi_clk edges only count while selected
            edges.sclk_rise <= sync2.sclk & ~sync3.sclk & sync2.cs;
            edges.sclk_fall <= ~sync2.sclk & sync3.sclk & sync2.cs;
            // select dropped, end of frame
            edges.cs_end    <= ~sync2.cs & sync3.cs;
        end
    end

endmodule

// File: hdl/spi_frame_slave.sv
`timescale 1ns/100ps

module spi_frame_slave (
    input  logic                    clk,
    input  logic                    reset_n,
    input  spi_reg_pkg::spi_pins_t  pins,
    input  spi_reg_pkg::spi_edges_t edges,
    input  spi_reg_pkg::reg_data_t  rdata,
    output spi_reg_pkg::reg_req_t   req,
    output logic                    miso_data,
    output logic                    miso_oe
);
    import spi_reg_pkg::*;

    // enough to count a full frame
    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    // bits received in this frame
    logic [CNT_W-1:0] bit_cnt;
    // r/w flag, 1 = read
    logic             frame_rd;
    // last address bit just arrived
    logic             addr_stb;
    logic             rd_stb;
    // bank data valid this cycle
    logic             rd_stb_d;
    logic             wr_stb;
    reg_addr_t        addr_q;
    reg_data_t        wdata_q;
    // low bits hold the address, later the data byte
    reg_data_t        shift_in;
    reg_data_t        shift_out;

    //////////////////////////////////////////////////////////////////////
    // bit counter and address strobe
    //////////////////////////////////////////////////////////////////////

    // both clear while deselected
    always_ff @(posedge clk) begin
        if (!reset_n || !pins.cs) begin
            bit_cnt  <= '0;
            addr_stb <= 1'b0;
        end else begin
            addr_stb <= 1'b0;
            if (edges.sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                // count ADDR_W means flag plus all address bits are in
                if (bit_cnt == CNT_W'(ADDR_W)) begin
                    addr_stb <= 1'b1;
                end
            end
        end
    end

    // flag from the first rising edge
    // held past the select drop for the write strobe
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            frame_rd <= 1'b0;
        end else if (edges.sclk_rise && bit_cnt == '0) begin
            frame_rd <= pins.mosi;
        end
    end

    // mosi in, lsb end
    always_ff @(posedge clk) begin
        if (edges.sclk_rise) begin
            shift_in <= {shift_in[DATA_W-2:0], pins.mosi};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_stb   <= 1'b0;
            rd_stb_d <= 1'b0;
            wr_stb   <= 1'b0;
        end else begin
            rd_stb   <= addr_stb & frame_rd;
            rd_stb_d <= rd_stb;
            // write commits only once the whole frame is in
            wr_stb   <= edges.cs_end & ~frame_rd;
        end
    end

    // address and write data, aligned with their strobes
    always_ff @(posedge clk) begin
        if (addr_stb) begin
            addr_q <= shift_in[ADDR_W-1:0];
        end
        if (edges.cs_end) begin
            wdata_q <= shift_in;
        end
    end

    always_comb begin
        req.rd_stb = rd_stb;
        req.wr_stb = wr_stb;
        req.addr   = addr_q;
        req.wdata  = wdata_q;
    end

    //////////////////////////////////////////////////////////////////////
    // miso path
    //////////////////////////////////////////////////////////////////////

    // driver on from the data phase until deselect
    always_ff @(posedge clk) begin
        if (!reset_n || !pins.cs) begin
            miso_oe <= 1'b0;
        end else if (addr_stb) begin
            miso_oe <= 1'b1;
        end
    end

    // load read byte, then msb first on each falling edge
    // master samples on the following rising edge
    always_ff @(posedge clk) begin
        if (rd_stb_d) begin
            shift_out <= rdata;
        end else if (edges.sclk_fall && miso_oe) begin
            miso_data <= shift_out[DATA_W-1];
            shift_out <= {shift_out[DATA_W-2:0], 1'b0};
        end
    end

endmodule

// File: hdl/spi_reg_bank.sv
`timescale 1ns/100ps

module spi_reg_bank #(
    parameter int NUM_REGS = 16
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  spi_reg_pkg::reg_req_t  req,
    input  spi_reg_pkg::reg_data_t status_in,
    output spi_reg_pkg::reg_data_t rdata,
    output spi_reg_pkg::reg_data_t ctrl_out
);
    import spi_reg_pkg::*;

    // index bits for the storage array, at least one
    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    reg_data_t        regs [NUM_REGS];
    logic [IDX_W-1:0] idx;
    // address hits the r/w storage
    logic             in_range;
    reg_data_t        rd_mux;

    assign idx      = req.addr[IDX_W-1:0];
    assign in_range = (req.addr < reg_addr_t'(NUM_REGS));

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // out of range writes fall through, status included
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (req.wr_stb && in_range) begin
            regs[idx] <= req.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read back
    //////////////////////////////////////////////////////////////////////

    // status first, then storage, anything else reads 0
    always_comb begin
        if (req.addr == STATUS_ADDR) begin
            rd_mux = status_in;
        end else if (in_range) begin
            rd_mux = regs[idx];
        end else begin
            rd_mux = '0;
        end
    end

    // valid the cycle after the read strobe
    always_ff @(posedge clk) begin
        if (req.rd_stb) begin
            rdata <= rd_mux;
        end
    end

    // register 0 out to the fabric, one register delay
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= regs[0];
        end
    end

endmodule

// File: hdl/spi_reg_top.sv
`timescale 1ns/100ps

module spi_reg_top #(
    parameter int NUM_REGS = 16
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   spi_cs0,
    input  logic                   spi_clk,
    input  logic                   spi_mosi,
    output tri logic               spi_miso,
    input  spi_reg_pkg::reg_data_t status_in,
    output spi_reg_pkg::reg_data_t ctrl_out
);
    import spi_reg_pkg::*;

    spi_pins_t  pins;
    spi_edges_t edges;
    reg_req_t   req;
    reg_data_t  rdata;
    logic       miso_data;
    logic       miso_oe;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    spi_pin_sync i_spi_pin_sync (
        .clk      (clk),
        .reset_n  (reset_n),
        .spi_cs0  (spi_cs0),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .pins     (pins),
        .edges    (edges)
    );

    spi_frame_slave i_spi_frame_slave (
        .clk       (clk),
        .reset_n   (reset_n),
        .pins      (pins),
        .edges     (edges),
        .rdata     (rdata),
        .req       (req),
        .miso_data (miso_data),
        .miso_oe   (miso_oe)
    );

    // shared miso line, released outside the data phase
    assign spi_miso = miso_oe ? miso_data : 1'bz;

    //////////////////////////////////////////////////////////////////////
    // register side
    //////////////////////////////////////////////////////////////////////

    spi_reg_bank #(
        .NUM_REGS (NUM_REGS)
    ) i_spi_reg_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .req       (req),
        .status_in (status_in),
        .rdata     (rdata),
        .ctrl_out  (ctrl_out)
    );

endmodule

// File: tb/tb_spi_reg_top.sv
`timescale 1ns/100ps

module tb_spi_reg_top;
    import spi_reg_pkg::*;

    localparam int NUM_REGS   = 16;
    localparam int IDX_W      = $clog2(NUM_REGS);
    localparam int CLK_NS     = 8;
    // spi bit period in clk cycles so spi_clk runs at clk/8
    localparam int BIT_CYC    = 8;
    localparam int BIT_NS     = BIT_CYC * CLK_NS;
    localparam int N_RAND     = 12;
    localparam int N_STATUS   = 4;
    localparam int N_OOR      = 4;
    // reset reads, write/read pairs, two sweeps, ctrl write, status reads, out of range pairs
    localparam int NUM_FRAMES = 4 + 2 * N_RAND + 2 * NUM_REGS + 1 + N_STATUS + 2 * N_OOR;
    // cs setup half bit, frame, cs hold half bit, two idle bits
    localparam int FRAME_NS   = (FRAME_BITS + 3) * BIT_NS;
    localparam int LIMIT_NS   = NUM_FRAMES * FRAME_NS + 10000;

    logic      clk;
    logic      reset_n;
    logic      spi_cs0;
    logic      spi_clk;
    logic      spi_mosi;
    tri        spi_miso;
    reg_data_t status_in;
    reg_data_t ctrl_out;

    // reference copy of the r/w bytes
    reg_data_t model [NUM_REGS];
    int        errors = 0;
    int        checks = 0;
    int        seed;
    // pending comparisons for the compare process
    reg_data_t exp_q [$];
    reg_data_t got_q [$];
    string     name_q [$];

    spi_reg_top #(
        .NUM_REGS (NUM_REGS)
    ) i_spi_reg_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .spi_cs0   (spi_cs0),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .status_in (status_in),
        .ctrl_out  (ctrl_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_NS / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model and compare
    //////////////////////////////////////////////////////////////////////

    // expected byte for a read of addr
    function automatic reg_data_t ref_read(input reg_addr_t addr);
        if (addr < reg_addr_t'(NUM_REGS)) begin
            return model[addr[IDX_W-1:0]];
        end else if (addr == STATUS_ADDR) begin
            return status_in;
        end
        return '0;
    endfunction

    task automatic check(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic push_compare(input string name, input reg_data_t got, input reg_data_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // drains all pending comparisons on each falling edge
    initial begin
        forever begin
            @(negedge clk);
            while (exp_q.size() > 0) begin
                check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // spi master model
    //////////////////////////////////////////////////////////////////////

    task automatic half_bit();
        repeat (BIT_CYC / 2) @(negedge clk);
    endtask

    // one mode 0 frame with flag then address then data msb first
    task automatic spi_frame(input logic rd, input reg_addr_t addr, input reg_data_t wdata,
                             output reg_data_t rdata);
        logic [FRAME_BITS-1:0] frame;
        frame   = {rd, addr, wdata};
        rdata   = '0;
        spi_cs0 = 1'b1;
        half_bit();
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            spi_mosi = frame[i];
            half_bit();
            // miso sampled just before each rising edge of the data phase
            if (i < DATA_W) begin
                rdata = {rdata[DATA_W-2:0], spi_miso};
            end
            spi_clk = 1'b1;
            half_bit();
            spi_clk = 1'b0;
        end
        half_bit();
        spi_cs0 = 1'b0;
        // idle lets the write strobe and ctrl_out settle
        repeat (2 * BIT_CYC) @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_data_t ignored;
        spi_frame(1'b0, addr, data, ignored);
        // out of range writes never reach the model
        if (addr < reg_addr_t'(NUM_REGS)) begin
            model[addr[IDX_W-1:0]] = data;
        end
    endtask

    task automatic read_check(input reg_addr_t addr);
        reg_data_t got;
        spi_frame(1'b1, addr, 8'h00, got);
        push_compare($sformatf("spi_miso addr 0x%h", addr), got, ref_read(addr));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reg_addr_t addr;
        reg_data_t data;
        seed      = 26;
        reset_n   = 1'b0;
        spi_cs0   = 1'b0;
        spi_clk   = 1'b0;
        spi_mosi  = 1'b0;
        status_in = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // reset values
        push_compare("ctrl_out", ctrl_out, 8'h00);
        for (int i = 0; i < 4; i++) begin
            read_check(reg_addr_t'(i));
        end

        // random write then read back
        for (int n = 0; n < N_RAND; n++) begin
            addr = reg_addr_t'($unsigned($random(seed)) % NUM_REGS);
            data = reg_data_t'($random(seed));
            write_reg(addr, data);
            read_check(addr);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            read_check(reg_addr_t'(i));
        end

        // register 0 out on ctrl_out
        data = reg_data_t'($random(seed));
        write_reg(reg_addr_t'(0), data);
        push_compare("ctrl_out", ctrl_out, model[0]);

        // status byte follows status_in
        for (int n = 0; n < N_STATUS; n++) begin
            status_in = reg_data_t'($random(seed));
            read_check(STATUS_ADDR);
        end

        // unmapped addresses drop writes and read 0
        for (int n = 0; n < N_OOR; n++) begin
            addr = reg_addr_t'(NUM_REGS
                + $unsigned($random(seed)) % (int'(STATUS_ADDR) - NUM_REGS));
            write_reg(addr, reg_data_t'($random(seed)));
            read_check(addr);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            read_check(reg_addr_t'(i));
        end

        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the frame count
    initial begin
        #(LIMIT_NS);
        $display("timeout: the test did not finish within %0d ns", LIMIT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: list.f
hdl/spi_reg_pkg.sv
hdl/spi_pin_sync.sv
hdl/spi_frame_slave.sv
hdl/spi_reg_bank.sv
hdl/spi_reg_top.sv
tb/tb_spi_reg_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_spi_reg_top -o tb_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
